/* Makefile */
# Verilator build and run for the decode stage testbench

SOURCES := $(filter-out +%,$(shell cat filelist.f)) src/decode_config.svh

.PHONY: run clean

run: obj_dir/Vdecode_tb
	@out="$$(./obj_dir/Vdecode_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

obj_dir/Vdecode_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --top-module decode_tb -f filelist.f

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+src
src/decode_pkg.sv
src/decode_ctrl.sv
src/inst_buffer.sv
src/decode_table.sv
src/issue_reg.sv
src/decode_top.sv
sim/tb_clock.sv
sim/decode_checker.sv
sim/decode_tb.sv

/* sim/decode_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the decode stage ports, bound into decode_top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_checker import decode_pkg::*; (
    input wire                      clk,
    input wire                      reset,
    input wire                      fetch_ready,
    input wire                      exec_valid,
    input wire                      exec_ready,
    input alu_op_e                  alu_op,
    input wire  [`DEC_SHIFT_W-1:0]  shift,
    input wire  [1:0]               shift_dir,
    input wire  [`DEC_IMM_W-1:0]    imm,
    input wire  [`DEC_REG_W-1:0]    rd,
    input wire  [`DEC_REG_W-1:0]    rm,
    input wire  [`DEC_REG_W-1:0]    rn,
    input mem_op_e                  mem_op,
    input wire                      write_rd,
    input wire                      use_imm,
    input wire  [3:0]               cond,
    input wire                      illegal,
    input wire  [`DEC_NUM_INT-1:0]  int_line
);

    // A stalled record stays put until execute takes it
    stall_holds: assert property (@(posedge clk) disable iff (reset)
        exec_valid && !exec_ready |=> exec_valid && $stable({alu_op, shift, shift_dir,
            imm, rd, rm, rn, mem_op, write_rd, use_imm, cond, illegal, int_line}))
        else $error("record or exec_valid changed while execute was stalled");

    int_one_hot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(int_line))
        else $error("more than one interrupt line raised");

    int_idle_low: assert property (@(posedge clk) disable iff (reset)
        !exec_valid |-> int_line == '0)
        else $error("interrupt line raised with no record presented");

    ready_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> fetch_ready)
        else $error("fetch_ready low in the first cycle after reset");

endmodule

bind decode_top decode_checker u_checker (.*);

`default_nettype wire

/* sim/decode_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the decode stage that streams words through both handshakes
// and checks each record against a reference decode of the word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_tb import decode_pkg::*; ();

    localparam int CYCLE_LIMIT = 2000;
    localparam logic [7:0] KEPT_OPS [19] = '{
        8'h10, 8'h14, 8'h30, 8'h34, 8'h24, 8'h25, 8'h40, 8'h42, 8'h44, 8'h45,
        8'h46, 8'h48, 8'h4A, 8'h4C, 8'h4D, 8'h4E, 8'h62, 8'h6A, 8'h70
    };

    typedef struct packed {
        alu_op_e                 alu_op;
        logic [`DEC_SHIFT_W-1:0] shift;
        logic [1:0]              shift_dir;
        logic [`DEC_IMM_W-1:0]   imm;
        logic [`DEC_REG_W-1:0]   rd;
        logic [`DEC_REG_W-1:0]   rm;
        logic [`DEC_REG_W-1:0]   rn;
        mem_op_e                 mem_op;
        logic                    write_rd;
        logic                    use_imm;
        logic [3:0]              cond;
        logic                    illegal;
        logic [`DEC_NUM_INT-1:0] int_line;
    } record_t;

    logic                    clk;
    logic                    reset;
    logic                    fetch_valid;
    logic [`DEC_INST_W-1:0]  fetch_inst;
    logic                    fetch_ready;
    logic                    exec_valid;
    logic                    exec_ready;
    alu_op_e                 alu_op;
    logic [`DEC_SHIFT_W-1:0] shift;
    logic [1:0]              shift_dir;
    logic [`DEC_IMM_W-1:0]   imm;
    logic [`DEC_REG_W-1:0]   rd;
    logic [`DEC_REG_W-1:0]   rm;
    logic [`DEC_REG_W-1:0]   rn;
    mem_op_e                 mem_op;
    logic                    write_rd;
    logic                    use_imm;
    logic [3:0]              cond;
    logic                    illegal;
    logic [`DEC_NUM_INT-1:0] int_line;

    logic [31:0] lcg_state = 32'hdad2;
    logic [31:0] stim_q [$];  // Words still to offer to fetch
    logic [31:0] sent_q [$];  // Accepted, record not yet taken
    string       test_name = "reset";
    int          records_checked = 0;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

    decode_top DUT (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_ready (fetch_ready),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .alu_op      (alu_op),
        .shift       (shift),
        .shift_dir   (shift_dir),
        .imm         (imm),
        .rd          (rd),
        .rm          (rm),
        .rn          (rn),
        .mem_op      (mem_op),
        .write_rd    (write_rd),
        .use_imm     (use_imm),
        .cond        (cond),
        .illegal     (illegal),
        .int_line    (int_line)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic roll_below(input int unsigned pct);
        logic [31:0] r;
        r = next_random();
        return ((r >> 8) % 32'd100) < pct;  // Low bits of an LCG repeat quickly
    endfunction

    function automatic logic known_opcode(input logic [7:0] op);
        logic hit;
        hit = (op[7:4] == 4'h5);  // Whole branch row
        for (int i = 0; i < 19; i++) begin
            if (op == KEPT_OPS[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic record_t expected_record(input logic [31:0] w);
        record_t    r;
        logic [7:0] op;
        logic       is_branch;
        logic       is_load;
        logic       is_store;
        logic       reg_form;  // Keeps shift fields
        logic       imm_form;  // Keeps imm
        op        = w[31:24];
        is_branch = (op[7:4] == 4'h5);
        is_load   = (op == 8'h10) || (op == 8'h14);
        is_store  = (op == 8'h30) || (op == 8'h34);
        reg_form  = op inside {8'h25, 8'h40, 8'h42, 8'h44, 8'h45, 8'h46, 8'h62};
        imm_form  = is_branch || (op inside {8'h10, 8'h30, 8'h24, 8'h48, 8'h4A,
                                             8'h4C, 8'h4D, 8'h4E, 8'h6A, 8'h70});
        r = '0;
        if (!known_opcode(op)) begin
            r.illegal = 1'b1;
            return r;
        end
        r.rd        = w[23:20];
        r.rm        = w[19:16];
        r.rn        = w[15:12];
        r.shift     = reg_form ? w[11:7] : 5'd0;
        r.shift_dir = reg_form ? w[6:5] : 2'd0;
        r.imm       = imm_form ? w[15:0] : 16'd0;
        r.use_imm   = is_load || is_store || is_branch ||
                      (op inside {8'h24, 8'h48, 8'h4A, 8'h4C, 8'h4D, 8'h4E, 8'h6A});
        r.write_rd  = is_load || (op inside {8'h24, 8'h25, 8'h40, 8'h42, 8'h44, 8'h45,
                                             8'h46, 8'h48, 8'h4A, 8'h4C, 8'h4D, 8'h4E});
        r.mem_op    = is_load ? MEM_LOAD : (is_store ? MEM_STORE : MEM_NONE);
        r.cond      = is_branch ? op[3:0] : 4'd0;
        case (op)
            8'h10, 8'h14, 8'h30, 8'h34, 8'h40, 8'h48: r.alu_op = ALU_ADD;
            8'h42, 8'h4A, 8'h62, 8'h6A:               r.alu_op = ALU_SUB;
            8'h44, 8'h4C:                             r.alu_op = ALU_AND;
            8'h45, 8'h4D:                             r.alu_op = ALU_OR;
            8'h46, 8'h4E:                             r.alu_op = ALU_XOR;
            8'h24, 8'h25:                             r.alu_op = ALU_MOV;
            default: r.alu_op = is_branch ? ALU_ADD : ALU_NOP;  // INT lands here
        endcase
        if (op == 8'h70 && w[15:0] < 16'd24) begin
            r.int_line = 24'd1 << w[15:0];
        end
        return r;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_value(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s expected %h actual %h", test_name, field, expected, actual);
            report_failure("value mismatch");
        end
    endtask

    task automatic check_record(input logic [31:0] word);
        record_t e;
        e = expected_record(word);
        compare_value("alu_op", 32'(e.alu_op), 32'(alu_op));
        compare_value("shift", 32'(e.shift), 32'(shift));
        compare_value("shift_dir", 32'(e.shift_dir), 32'(shift_dir));
        compare_value("imm", 32'(e.imm), 32'(imm));
        compare_value("rd", 32'(e.rd), 32'(rd));
        compare_value("rm", 32'(e.rm), 32'(rm));
        compare_value("rn", 32'(e.rn), 32'(rn));
        compare_value("mem_op", 32'(e.mem_op), 32'(mem_op));
        compare_value("write_rd", 32'(e.write_rd), 32'(write_rd));
        compare_value("use_imm", 32'(e.use_imm), 32'(use_imm));
        compare_value("cond", 32'(e.cond), 32'(cond));
        compare_value("illegal", 32'(e.illegal), 32'(illegal));
        compare_value("int_line", 32'(e.int_line), 32'(int_line));
        records_checked++;
    endtask

    // Scoreboard sampled mid-cycle where both handshakes are settled
    always @(negedge clk) begin
        if (!reset) begin
            if (exec_valid && exec_ready) begin
                if (sent_q.size() == 0) begin
                    report_failure("execute took a record that fetch never sent");
                end else begin
                    check_record(sent_q.pop_front());
                end
            end
            if (fetch_valid && fetch_ready) begin
                sent_q.push_back(fetch_inst);
            end
        end
    end

    // Offers stim_q to fetch until every outstanding record reached execute
    task automatic run_stream(input int unsigned gap_pct, input int unsigned stall_pct,
                              output int span);
        int          target;
        int          xfers;
        int          cycles;
        int          first;
        int          last;
        target = stim_q.size() + sent_q.size();
        xfers  = 0;
        cycles = 0;
        first  = -1;
        last   = -1;
        while (xfers < target && cycles < CYCLE_LIMIT) begin
            fetch_valid = (stim_q.size() > 0) && !roll_below(gap_pct);
            fetch_inst  = (stim_q.size() > 0) ? stim_q[0] : 32'd0;
            exec_ready  = !roll_below(stall_pct);
            @(negedge clk);
            if (fetch_valid && fetch_ready) begin
                void'(stim_q.pop_front());
            end
            if (exec_valid && exec_ready) begin
                if (first < 0) begin
                    first = cycles;
                end
                last = cycles;
                xfers++;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (xfers < target) begin
            report_failure("records did not reach execute within the cycle limit");
        end
        fetch_valid = 1'b0;
        exec_ready  = 1'b0;
        compare_value("exec_valid after drain", 32'd0, 32'(exec_valid));
        span = last - first;
    endtask

    // Fetch keeps offering under an execute stall until the decoder pushes back
    task automatic fill_while_stalled();
        int          accepted;
        int          cycles;
        accepted    = 0;
        cycles      = 0;
        exec_ready  = 1'b0;
        fetch_valid = 1'b1;
        fetch_inst  = stim_q[0];
        @(negedge clk);
        while (fetch_ready && cycles < 20) begin
            void'(stim_q.pop_front());
            accepted++;
            @(posedge clk);
            #1;
            cycles++;
            fetch_inst = stim_q[0];
            @(negedge clk);
        end
        if (fetch_ready) begin
            report_failure("fetch_ready stayed high while execute was stalled");
        end
        compare_value("words held under stall", 32'd2, 32'(accepted));
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int          span;
        int          found;
        int          tries;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_inst  = '0;
        exec_ready  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        compare_value("fetch_ready", 32'd1, 32'(fetch_ready));
        compare_value("exec_valid", 32'd0, 32'(exec_valid));
        @(posedge clk);
        #1;

        test_name = "kept opcodes";
        for (int i = 0; i < 19; i++) begin
            for (int n = 0; n < 3; n++) begin
                r = next_random();
                stim_q.push_back({KEPT_OPS[i], r[23:0]});
            end
        end
        run_stream(10, 20, span);

        test_name = "branches";
        for (int c = 0; c < 16; c++) begin
            r = next_random();
            stim_q.push_back({4'h5, c[3:0], r[23:0]});
        end
        run_stream(0, 30, span);

        test_name = "interrupts";
        for (int n = 0; n < 28; n++) begin
            r = next_random();
            stim_q.push_back({8'h70, r[7:0], 16'(n)});
        end
        stim_q.push_back({8'h70, 8'h3c, 16'h0100});
        stim_q.push_back({8'h70, 8'hc3, 16'hffff});
        run_stream(20, 20, span);

        test_name = "unknown opcodes";
        found = 0;
        tries = 0;
        while (found < 12 && tries < 1000) begin
            r = next_random();
            tries++;
            if (!known_opcode(r[31:24])) begin
                stim_q.push_back(r);
                found++;
            end
        end
        run_stream(0, 0, span);

        test_name = "random back-pressure";
        for (int n = 0; n < 60; n++) begin
            r = next_random();
            if (r[0]) begin
                r[31:24] = KEPT_OPS[r[12:8] % 5'd19];  // Bias toward valid opcodes
            end
            stim_q.push_back(r);
        end
        run_stream(30, 40, span);

        test_name = "stall fill";
        for (int n = 0; n < 4; n++) begin
            r = next_random();
            stim_q.push_back({KEPT_OPS[n + 6], r[23:0]});
        end
        fill_while_stalled();
        run_stream(0, 0, span);

        test_name = "throughput";
        for (int n = 0; n < 16; n++) begin
            r = next_random();
            stim_q.push_back({KEPT_OPS[n], r[23:0]});
        end
        run_stream(0, 0, span);
        compare_value("cycles first to last record", 32'd15, 32'(span));

        if (records_checked > 0 && sent_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_failure("no records were checked or some were left over");
        end
    end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock, period set by parameter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;  // Half period per toggle
        end
    end

endmodule

`default_nettype wire

/* src/decode_config.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field widths and counts for the decode stage
// Include this wherever a port or field width is needed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define DEC_INST_W  32  // Instruction word
`define DEC_REG_W   4   // Register index, 16 registers
`define DEC_SHIFT_W 5   // Shift amount
`define DEC_IMM_W   16  // Immediate
`define DEC_NUM_INT 24  // Software interrupt lines

`endif

/* src/decode_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Occupancy FSM for the two decode stages
// Drives both valid/ready handshakes and the stage load enables
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl import decode_pkg::*; (
    input  wire  clk,
    input  wire  reset,
    input  wire  fetch_valid,
    input  wire  exec_ready,
    output logic fetch_ready,
    output logic exec_valid,
    output logic load_in,   // Capture fetch word into buffer
    output logic load_out   // Move decoded record into issue register
);

    pipe_state_e state;
    pipe_state_e state_next;
    logic        buf_full;
    logic        out_full;
    logic        buf_next;
    logic        out_next;

    assign buf_full = (state == ST_IN_ONLY) || (state == ST_BOTH);
    assign out_full = (state == ST_OUT_ONLY) || (state == ST_BOTH);

    assign exec_valid  = out_full;
    assign load_out    = buf_full && (!out_full || exec_ready);  // Empty or draining
    assign fetch_ready = !buf_full || load_out;
    assign load_in     = fetch_valid && fetch_ready;

    // Stage is full next cycle if loaded now, or kept and not moved on
    assign buf_next = load_in || (buf_full && !load_out);
    assign out_next = load_out || (out_full && !exec_ready);

    always_comb begin
        case ({buf_next, out_next})
            2'b00:   state_next = ST_EMPTY;
            2'b10:   state_next = ST_IN_ONLY;
            2'b01:   state_next = ST_OUT_ONLY;
            default: state_next = ST_BOTH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_EMPTY;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

/* src/decode_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Enum types shared by the decode stage and its testbench
// Opcode encodings, ALU and memory operations, pipeline occupancy
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package decode_pkg;

    typedef enum logic [7:0] {
        OP_LDRI = 8'h10,  // Rd <- [Rm + imm]
        OP_LDR  = 8'h14,  // Rd <- [Rm]
        OP_MOVI = 8'h24,
        OP_MOVN = 8'h25,  // Rd <- sh(Rn)
        OP_STRI = 8'h30,
        OP_STR  = 8'h34,
        OP_ADD  = 8'h40,
        OP_SUB  = 8'h42,
        OP_AND  = 8'h44,
        OP_OR   = 8'h45,
        OP_XOR  = 8'h46,
        OP_ADDI = 8'h48,
        OP_SUBI = 8'h4A,
        OP_ANDI = 8'h4C,
        OP_ORI  = 8'h4D,
        OP_XORI = 8'h4E,
        OP_BRCH = 8'h50,  // Base of 0x50..0x5F, low nibble is cond
        OP_CMP  = 8'h62,
        OP_CMPI = 8'h6A,
        OP_INT  = 8'h70
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MOV
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_op_e;

    // Which of the two stages hold an instruction
    typedef enum logic [1:0] {
        ST_EMPTY, ST_IN_ONLY, ST_OUT_ONLY, ST_BOTH
    } pipe_state_e;

endpackage

`default_nettype wire

/* src/decode_table.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational opcode lookup, gives ALU operation, control fields
// and the operand fields each instruction actually uses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_table import decode_pkg::*; (
    input  opcode_e                  opcode,
    input  wire  [`DEC_REG_W-1:0]    rd,
    input  wire  [`DEC_REG_W-1:0]    rm,
    input  wire  [`DEC_REG_W-1:0]    rn,
    input  wire  [`DEC_SHIFT_W-1:0]  shift,
    input  wire  [1:0]               shift_dir,
    input  wire  [`DEC_IMM_W-1:0]    imm,
    output alu_op_e                  dec_alu_op,
    output logic [`DEC_SHIFT_W-1:0]  dec_shift,
    output logic [1:0]               dec_shift_dir,
    output logic [`DEC_IMM_W-1:0]    dec_imm,
    output logic [`DEC_REG_W-1:0]    dec_rd,
    output logic [`DEC_REG_W-1:0]    dec_rm,
    output logic [`DEC_REG_W-1:0]    dec_rn,
    output mem_op_e                  dec_mem_op,
    output logic                     dec_write_rd,
    output logic                     dec_use_imm,
    output logic [3:0]               dec_cond,
    output logic                     dec_illegal,
    output logic                     int_req
);

    logic keep_shift;  // Register forms use sh(Rn)
    logic keep_imm;

    // ALU groups 0x40 and 0x48 share the low three opcode bits
    function automatic alu_op_e logic_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return ALU_ADD;
            3'd2:    return ALU_SUB;
            3'd4:    return ALU_AND;
            3'd5:    return ALU_OR;
            default: return ALU_XOR;
        endcase
    endfunction

    always_comb begin
        dec_alu_op   = ALU_NOP;
        dec_mem_op   = MEM_NONE;
        dec_write_rd = 1'b0;
        dec_use_imm  = 1'b0;
        dec_cond     = 4'd0;
        dec_illegal  = 1'b0;
        int_req      = 1'b0;
        keep_shift   = 1'b0;
        keep_imm     = 1'b0;

        case (opcode)
            OP_LDRI, OP_LDR: begin
                dec_alu_op   = ALU_ADD;  // Address Rm + imm
                dec_mem_op   = MEM_LOAD;
                dec_write_rd = 1'b1;
                dec_use_imm  = 1'b1;
                keep_imm     = (opcode == OP_LDRI);
            end
            OP_STRI, OP_STR: begin
                dec_alu_op  = ALU_ADD;
                dec_mem_op  = MEM_STORE;
                dec_use_imm = 1'b1;
                keep_imm    = (opcode == OP_STRI);
            end
            OP_MOVI: begin
                dec_alu_op   = ALU_MOV;
                dec_write_rd = 1'b1;
                dec_use_imm  = 1'b1;
                keep_imm     = 1'b1;
            end
            OP_MOVN: begin
                dec_alu_op   = ALU_MOV;
                dec_write_rd = 1'b1;
                keep_shift   = 1'b1;
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                dec_alu_op   = logic_op(opcode[2:0]);
                dec_write_rd = 1'b1;
                keep_shift   = 1'b1;
            end
            OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_XORI: begin
                dec_alu_op   = logic_op(opcode[2:0]);
                dec_write_rd = 1'b1;
                dec_use_imm  = 1'b1;
                keep_imm     = 1'b1;
            end
            OP_CMP: begin
                dec_alu_op = ALU_SUB;  // Flags only
                keep_shift = 1'b1;
            end
            OP_CMPI: begin
                dec_alu_op  = ALU_SUB;
                dec_use_imm = 1'b1;
                keep_imm    = 1'b1;
            end
            OP_INT: begin
                keep_imm = 1'b1;  // Interrupt number
                int_req  = 1'b1;
            end
            default: begin
                if ((opcode & 8'hF0) == OP_BRCH) begin
                    dec_alu_op  = ALU_ADD;  // PC + offset
                    dec_use_imm = 1'b1;
                    dec_cond    = opcode[3:0];
                    keep_imm    = 1'b1;
                end else begin
                    dec_illegal = 1'b1;
                end
            end
        endcase
    end

    assign dec_shift     = keep_shift ? shift : '0;
    assign dec_shift_dir = keep_shift ? shift_dir : 2'b00;
    assign dec_imm       = keep_imm ? imm : '0;

    // Register indices pass through unless the opcode is unknown
    assign dec_rd = dec_illegal ? '0 : rd;
    assign dec_rm = dec_illegal ? '0 : rm;
    assign dec_rn = dec_illegal ? '0 : rn;

endmodule

`default_nettype wire

/* src/decode_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage top level, fetch handshake in and execute handshake out
// Two instructions in flight, one per cycle when execute keeps up
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_top import decode_pkg::*; (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      fetch_valid,
    input  wire  [`DEC_INST_W-1:0]   fetch_inst,
    output logic                     fetch_ready,
    output logic                     exec_valid,
    input  wire                      exec_ready,
    output alu_op_e                  alu_op,
    output logic [`DEC_SHIFT_W-1:0]  shift,
    output logic [1:0]               shift_dir,
    output logic [`DEC_IMM_W-1:0]    imm,
    output logic [`DEC_REG_W-1:0]    rd,
    output logic [`DEC_REG_W-1:0]    rm,
    output logic [`DEC_REG_W-1:0]    rn,
    output mem_op_e                  mem_op,
    output logic                     write_rd,
    output logic                     use_imm,
    output logic [3:0]               cond,
    output logic                     illegal,
    output logic [`DEC_NUM_INT-1:0]  int_line
);

    logic load_in;
    logic load_out;

    // Fields of the buffered word
    opcode_e                 buf_opcode;
    logic [`DEC_REG_W-1:0]   buf_rd;
    logic [`DEC_REG_W-1:0]   buf_rm;
    logic [`DEC_REG_W-1:0]   buf_rn;
    logic [`DEC_SHIFT_W-1:0] buf_shift;
    logic [1:0]              buf_shift_dir;
    logic [`DEC_IMM_W-1:0]   buf_imm;

    // Combinational record from the table
    alu_op_e                 dec_alu_op;
    logic [`DEC_SHIFT_W-1:0] dec_shift;
    logic [1:0]              dec_shift_dir;
    logic [`DEC_IMM_W-1:0]   dec_imm;
    logic [`DEC_REG_W-1:0]   dec_rd;
    logic [`DEC_REG_W-1:0]   dec_rm;
    logic [`DEC_REG_W-1:0]   dec_rn;
    mem_op_e                 dec_mem_op;
    logic                    dec_write_rd;
    logic                    dec_use_imm;
    logic [3:0]              dec_cond;
    logic                    dec_illegal;
    logic                    int_req;

    decode_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .exec_ready  (exec_ready),
        .fetch_ready (fetch_ready),
        .exec_valid  (exec_valid),
        .load_in     (load_in),
        .load_out    (load_out)
    );

    inst_buffer u_buffer (
        .clk        (clk),
        .load_in    (load_in),
        .fetch_inst (fetch_inst),
        .opcode     (buf_opcode),
        .rd         (buf_rd),
        .rm         (buf_rm),
        .rn         (buf_rn),
        .shift      (buf_shift),
        .shift_dir  (buf_shift_dir),
        .imm        (buf_imm)
    );

    decode_table u_table (
        .opcode        (buf_opcode),
        .rd            (buf_rd),
        .rm            (buf_rm),
        .rn            (buf_rn),
        .shift         (buf_shift),
        .shift_dir     (buf_shift_dir),
        .imm           (buf_imm),
        .dec_alu_op    (dec_alu_op),
        .dec_shift     (dec_shift),
        .dec_shift_dir (dec_shift_dir),
        .dec_imm       (dec_imm),
        .dec_rd        (dec_rd),
        .dec_rm        (dec_rm),
        .dec_rn        (dec_rn),
        .dec_mem_op    (dec_mem_op),
        .dec_write_rd  (dec_write_rd),
        .dec_use_imm   (dec_use_imm),
        .dec_cond      (dec_cond),
        .dec_illegal   (dec_illegal),
        .int_req       (int_req)
    );

    issue_reg u_issue (
        .clk           (clk),
        .reset         (reset),
        .load_out      (load_out),
        .exec_ready    (exec_ready),
        .dec_alu_op    (dec_alu_op),
        .dec_shift     (dec_shift),
        .dec_shift_dir (dec_shift_dir),
        .dec_imm       (dec_imm),
        .dec_rd        (dec_rd),
        .dec_rm        (dec_rm),
        .dec_rn        (dec_rn),
        .dec_mem_op    (dec_mem_op),
        .dec_write_rd  (dec_write_rd),
        .dec_use_imm   (dec_use_imm),
        .dec_cond      (dec_cond),
        .dec_illegal   (dec_illegal),
        .int_req       (int_req),
        .alu_op        (alu_op),
        .shift         (shift),
        .shift_dir     (shift_dir),
        .imm           (imm),
        .rd            (rd),
        .rm            (rm),
        .rn            (rn),
        .mem_op        (mem_op),
        .write_rd      (write_rd),
        .use_imm       (use_imm),
        .cond          (cond),
        .illegal       (illegal),
        .int_line      (int_line)
    );

endmodule

`default_nettype wire

/* src/inst_buffer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First decode stage, holds one accepted instruction word
// and splits it into the fields read by the opcode table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module inst_buffer import decode_pkg::*; (
    input  wire                      clk,
    input  wire                      load_in,
    input  wire  [`DEC_INST_W-1:0]   fetch_inst,
    output opcode_e                  opcode,
    output logic [`DEC_REG_W-1:0]    rd,
    output logic [`DEC_REG_W-1:0]    rm,
    output logic [`DEC_REG_W-1:0]    rn,
    output logic [`DEC_SHIFT_W-1:0]  shift,
    output logic [1:0]               shift_dir,
    output logic [`DEC_IMM_W-1:0]    imm
);

    logic [`DEC_INST_W-1:0] word;

    always_ff @(posedge clk) begin
        if (load_in) begin
            word <= fetch_inst;
        end
    end

    assign opcode    = opcode_e'(word[31:24]);
    assign rd        = word[23:20];
    assign rm        = word[19:16];
    assign rn        = word[15:12];  // Overlaps imm
    assign shift     = word[11:7];
    assign shift_dir = word[6:5];
    assign imm       = word[15:0];

endmodule

`default_nettype wire

/* src/issue_reg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second decode stage, holds the record presented to execute
// and turns an INT request into its one-hot interrupt line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module issue_reg import decode_pkg::*; (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      load_out,
    input  wire                      exec_ready,
    input  alu_op_e                  dec_alu_op,
    input  wire  [`DEC_SHIFT_W-1:0]  dec_shift,
    input  wire  [1:0]               dec_shift_dir,
    input  wire  [`DEC_IMM_W-1:0]    dec_imm,
    input  wire  [`DEC_REG_W-1:0]    dec_rd,
    input  wire  [`DEC_REG_W-1:0]    dec_rm,
    input  wire  [`DEC_REG_W-1:0]    dec_rn,
    input  mem_op_e                  dec_mem_op,
    input  wire                      dec_write_rd,
    input  wire                      dec_use_imm,
    input  wire  [3:0]               dec_cond,
    input  wire                      dec_illegal,
    input  wire                      int_req,
    output alu_op_e                  alu_op,
    output logic [`DEC_SHIFT_W-1:0]  shift,
    output logic [1:0]               shift_dir,
    output logic [`DEC_IMM_W-1:0]    imm,
    output logic [`DEC_REG_W-1:0]    rd,
    output logic [`DEC_REG_W-1:0]    rm,
    output logic [`DEC_REG_W-1:0]    rn,
    output mem_op_e                  mem_op,
    output logic                     write_rd,
    output logic                     use_imm,
    output logic [3:0]               cond,
    output logic                     illegal,
    output logic [`DEC_NUM_INT-1:0]  int_line
);

    logic [`DEC_NUM_INT-1:0] int_next;

    // Out-of-range interrupt numbers select no line
    always_comb begin
        for (int i = 0; i < `DEC_NUM_INT; i++) begin
            int_next[i] = int_req && (dec_imm == `DEC_IMM_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            alu_op    <= dec_alu_op;
            shift     <= dec_shift;
            shift_dir <= dec_shift_dir;
            imm       <= dec_imm;
            rd        <= dec_rd;
            rm        <= dec_rm;
            rn        <= dec_rn;
            mem_op    <= dec_mem_op;
            write_rd  <= dec_write_rd;
            use_imm   <= dec_use_imm;
            cond      <= dec_cond;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            illegal  <= 1'b0;
            int_line <= '0;
        end else if (load_out) begin
            illegal  <= dec_illegal;
            int_line <= int_next;
        end else if (exec_ready) begin
            int_line <= '0;  // Drained with nothing behind it
        end
    end

endmodule

`default_nettype wire
